/* run.sh */
#!/bin/sh
# build and run the CCU control testbench with Verilator
verilator --binary --timing -f verilog.f --top-module tb_ccu_ctrl -o sim_ccu_ctrl \
    && { ./obj_dir/sim_ccu_ctrl > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "CHECKS FAILED" sim.log \
    && grep -q "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* source/ccu_ctrl.sv */
`timescale 1ns/10ps

module ccu_ctrl import ccu_ctrl_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // read request
    input  logic      ar_valid_i,
    output logic      ar_ready_o,
    input  addr_t     ar_addr_i,
    input  axi_id_t   ar_id_i,
    input  snoop_t    ar_snoop_i,
    input  logic      ar_lock_i,
    // write request
    input  logic      aw_valid_i,
    output logic      aw_ready_o,
    input  addr_t     aw_addr_i,
    input  axi_id_t   aw_id_i,
    // snoop address
    output mst_mask_t ac_valid_o,
    input  mst_mask_t ac_ready_i,
    output addr_t     ac_addr_o,
    output snoop_t    ac_snoop_o,
    // snoop response
    input  mst_mask_t cr_valid_i,
    output mst_mask_t cr_ready_o,
    input  mst_mask_t cr_data_transfer_i,
    input  mst_mask_t cr_is_shared_i,
    input  mst_mask_t cr_pass_dirty_i,
    input  mst_mask_t cr_error_i,
    // memory unit
    output logic      mu_valid_o,
    input  logic      mu_ready_i,
    output mu_op_e    mu_op_o,
    // snoop data unit
    output logic      su_valid_o,
    input  logic      su_ready_i,
    output su_op_e    su_op_o,
    // lookup
    output logic      lookup_req_o,
    input  logic      collision_i,
    input  logic      b_queue_full_i,
    input  logic      r_queue_full_i
);

    logic        snoop_start;
    snoop_kind_e snoop_kind;
    addr_t       snoop_addr;
    snoop_t      snoop_code;
    mst_mask_t   initiator;
    logic        lock;
    logic        snoop_done;
    mst_mask_t   data_avail;
    logic        dispatch_done;

    ccu_req_decode i_req_decode (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .ar_valid_i      (ar_valid_i),
        .ar_addr_i       (ar_addr_i),
        .ar_id_i         (ar_id_i),
        .ar_snoop_i      (ar_snoop_i),
        .ar_lock_i       (ar_lock_i),
        .aw_valid_i      (aw_valid_i),
        .aw_addr_i       (aw_addr_i),
        .aw_id_i         (aw_id_i),
        .ar_ready_o      (ar_ready_o),
        .aw_ready_o      (aw_ready_o),
        .lookup_req_o    (lookup_req_o),
        .collision_i     (collision_i),
        .b_queue_full_i  (b_queue_full_i),
        .r_queue_full_i  (r_queue_full_i),
        .dispatch_done_i (dispatch_done),
        .snoop_start_o   (snoop_start),
        .snoop_kind_o    (snoop_kind),
        .snoop_addr_o    (snoop_addr),
        .snoop_code_o    (snoop_code),
        .initiator_o     (initiator),
        .lock_o          (lock)
    );

    ccu_snoop_execute i_snoop_execute (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .snoop_start_i      (snoop_start),
        .snoop_kind_i       (snoop_kind),
        .snoop_addr_i       (snoop_addr),
        .snoop_code_i       (snoop_code),
        .initiator_i        (initiator),
        .ac_valid_o         (ac_valid_o),
        .ac_ready_i         (ac_ready_i),
        .ac_addr_o          (ac_addr_o),
        .ac_snoop_o         (ac_snoop_o),
        .cr_valid_i         (cr_valid_i),
        .cr_ready_o         (cr_ready_o),
        .cr_data_transfer_i (cr_data_transfer_i),
        .cr_is_shared_i     (cr_is_shared_i),
        .cr_pass_dirty_i    (cr_pass_dirty_i),
        .cr_error_i         (cr_error_i),
        .snoop_done_o       (snoop_done),
        .data_avail_o       (data_avail),
        .shared_o           (),
        .dirty_o            (),
        .first_responder_o  ()
    );

    ccu_dispatch_result i_dispatch_result (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .snoop_done_i    (snoop_done),
        .snoop_kind_i    (snoop_kind),
        .lock_i          (lock),
        .data_avail_i    (data_avail),
        .mu_valid_o      (mu_valid_o),
        .mu_ready_i      (mu_ready_i),
        .mu_op_o         (mu_op_o),
        .su_valid_o      (su_valid_o),
        .su_ready_i      (su_ready_i),
        .su_op_o         (su_op_o),
        .dispatch_done_o (dispatch_done)
    );

endmodule

/* source/ccu_ctrl_pkg.sv */
package ccu_ctrl_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int unsigned NO_MST_PORTS = 4;
    localparam int unsigned MST_IDX_BITS = 2;
    localparam int unsigned ADDR_WIDTH   = 32;
    // top MST_IDX_BITS bits of the id name the initiator
    localparam int unsigned ID_WIDTH     = 6;

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [ID_WIDTH-1:0]     axi_id_t;
    typedef logic [MST_IDX_BITS-1:0] mst_idx_t;
    typedef logic [NO_MST_PORTS-1:0] mst_mask_t;
    typedef logic [3:0]              snoop_t;

    // --------------------
    // ace snoop codes
    // --------------------
    localparam snoop_t SNP_READ_SHARED   = 4'b0001;
    localparam snoop_t SNP_CLEAN_UNIQUE  = 4'b1011;
    localparam snoop_t SNP_CLEAN_INVALID = 4'b1001;

    // what the snoop phase is for
    typedef enum logic [1:0] {
        SNOOP_READ,
        SNOOP_READ_INVALID,
        SNOOP_WRITE_INVALID
    } snoop_kind_e;

    // memory unit ops
    typedef enum logic [1:0] {
        SEND_AXI_REQ_R,
        SEND_AXI_REQ_W,
        SEND_AXI_REQ_WRITE_BACK_R,
        SEND_AXI_REQ_WRITE_BACK_W
    } mu_op_e;

    // snoop data unit ops
    typedef enum logic {
        READ_SNP_DATA,
        SEND_INVALID_ACK_R
    } su_op_e;

endpackage

/* source/ccu_dispatch_result.sv */
`timescale 1ns/10ps

module ccu_dispatch_result import ccu_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    // snoop outcome
    input  logic        snoop_done_i,
    input  snoop_kind_e snoop_kind_i,
    input  logic        lock_i,
    input  mst_mask_t   data_avail_i,
    // memory unit
    output logic        mu_valid_o,
    input  logic        mu_ready_i,
    output mu_op_e      mu_op_o,
    // snoop data unit
    output logic        su_valid_o,
    input  logic        su_ready_i,
    output su_op_e      su_op_o,
    // back to decode
    output logic        dispatch_done_o
);

    logic   any_data;
    logic   mu_need, su_need;
    mu_op_e mu_op_d, mu_op_q;
    su_op_e su_op_d, su_op_q;
    logic   mu_valid_q, su_valid_q;

    assign any_data = |data_avail_i;

    // --------------------
    // op selection
    // --------------------
    always_comb begin
        mu_need = 1'b0;
        su_need = 1'b0;
        mu_op_d = SEND_AXI_REQ_R;
        su_op_d = READ_SNP_DATA;

        case (snoop_kind_i)
            SNOOP_READ: begin
                // another master holds the line
                su_need = any_data;
                mu_need = ~any_data;
            end
            SNOOP_READ_INVALID: begin
                mu_need = any_data | lock_i;
                mu_op_d = any_data ? SEND_AXI_REQ_WRITE_BACK_R : SEND_AXI_REQ_R;
                su_need = ~lock_i;
                su_op_d = SEND_INVALID_ACK_R;
            end
            default: begin
                mu_need = 1'b1;
                mu_op_d = any_data ? SEND_AXI_REQ_WRITE_BACK_W : SEND_AXI_REQ_W;
            end
        endcase
    end

    // each valid is held on its own until accepted
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            mu_valid_q <= 1'b0;
            su_valid_q <= 1'b0;
        end else if (snoop_done_i) begin
            mu_valid_q <= mu_need;
            su_valid_q <= su_need;
        end else begin
            mu_valid_q <= mu_valid_q & ~mu_ready_i;
            su_valid_q <= su_valid_q & ~su_ready_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (snoop_done_i) begin
            mu_op_q <= mu_op_d;
            su_op_q <= su_op_d;
        end
    end

    assign mu_valid_o = mu_valid_q;
    assign su_valid_o = su_valid_q;
    assign mu_op_o    = mu_op_q;
    assign su_op_o    = su_op_q;

    // done when the last pending valid is taken
    assign dispatch_done_o = (mu_valid_q | su_valid_q)
                           & (~mu_valid_q | mu_ready_i)
                           & (~su_valid_q | su_ready_i);

endmodule

/* source/ccu_req_decode.sv */
`timescale 1ns/10ps

module ccu_req_decode import ccu_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    // read request
    input  logic        ar_valid_i,
    input  addr_t       ar_addr_i,
    input  axi_id_t     ar_id_i,
    input  snoop_t      ar_snoop_i,
    input  logic        ar_lock_i,
    // write request
    input  logic        aw_valid_i,
    input  addr_t       aw_addr_i,
    input  axi_id_t     aw_id_i,
    output logic        ar_ready_o,
    output logic        aw_ready_o,
    // collision lookup
    output logic        lookup_req_o,
    input  logic        collision_i,
    input  logic        b_queue_full_i,
    input  logic        r_queue_full_i,
    // towards snoop execution
    input  logic        dispatch_done_i,
    output logic        snoop_start_o,
    output snoop_kind_e snoop_kind_o,
    output addr_t       snoop_addr_o,
    output snoop_t      snoop_code_o,
    output mst_mask_t   initiator_o,
    output logic        lock_o
);

    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        BUSY
    } state_e;

    state_e   state_d, state_q;
    logic     write_waiting_d, write_waiting_q;
    logic     pick_r, pick_w;
    logic     capture;
    logic     queue_full;
    mst_idx_t init_idx;

    // held request
    logic     is_read_q;
    addr_t    addr_q;
    axi_id_t  id_q;
    snoop_t   snoop_q;
    logic     lock_q;

    // reads win unless the previous read left a write waiting
    assign pick_r = ar_valid_i & (~aw_valid_i | ~write_waiting_q);
    assign pick_w = aw_valid_i & ~pick_r;

    assign queue_full = is_read_q ? r_queue_full_i : b_queue_full_i;

    always_ff @(posedge clk_i) begin
        if (capture) begin
            is_read_q <= pick_r;
            addr_q    <= pick_r ? ar_addr_i : aw_addr_i;
            id_q      <= pick_r ? ar_id_i : aw_id_i;
            snoop_q   <= pick_r ? ar_snoop_i : '0;
            lock_q    <= pick_r & ar_lock_i;
        end
    end

    // --------------------
    // state machine
    // --------------------
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            state_q         <= IDLE;
            write_waiting_q <= 1'b0;
        end else begin
            state_q         <= state_d;
            write_waiting_q <= write_waiting_d;
        end
    end

    always_comb begin
        state_d         = state_q;
        write_waiting_d = write_waiting_q;
        capture         = 1'b0;
        ar_ready_o      = 1'b0;
        aw_ready_o      = 1'b0;
        lookup_req_o    = 1'b0;
        snoop_start_o   = 1'b0;

        case (state_q)
            IDLE: begin
                if (pick_r | pick_w) begin
                    capture         = 1'b1;
                    write_waiting_d = pick_r & aw_valid_i;
                    state_d         = DECODE;
                end
            end
            DECODE: begin
                lookup_req_o = 1'b1;
                // accept only once the lookup is clear and there is room
                if (!collision_i && !queue_full) begin
                    ar_ready_o    = is_read_q;
                    aw_ready_o    = ~is_read_q;
                    snoop_start_o = 1'b1;
                    state_d       = BUSY;
                end
            end
            BUSY: begin
                if (dispatch_done_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // --------------------
    // snoop job
    // --------------------
    assign init_idx    = id_q[ID_WIDTH-1 -: MST_IDX_BITS];
    assign initiator_o = mst_mask_t'(1) << init_idx;

    always_comb begin
        if (!is_read_q) begin
            snoop_kind_o = SNOOP_WRITE_INVALID;
        end else if (snoop_q == SNP_CLEAN_UNIQUE || lock_q) begin
            snoop_kind_o = SNOOP_READ_INVALID;
        end else begin
            snoop_kind_o = SNOOP_READ;
        end
    end

    assign snoop_addr_o = addr_q;
    assign snoop_code_o = snoop_q;
    assign lock_o       = lock_q;

endmodule

/* source/ccu_snoop_execute.sv */
`timescale 1ns/10ps

module ccu_snoop_execute import ccu_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    // from decode
    input  logic        snoop_start_i,
    input  snoop_kind_e snoop_kind_i,
    input  addr_t       snoop_addr_i,
    input  snoop_t      snoop_code_i,
    input  mst_mask_t   initiator_i,
    // snoop address channel
    output mst_mask_t   ac_valid_o,
    input  mst_mask_t   ac_ready_i,
    output addr_t       ac_addr_o,
    output snoop_t      ac_snoop_o,
    // snoop response channel
    input  mst_mask_t   cr_valid_i,
    output mst_mask_t   cr_ready_o,
    input  mst_mask_t   cr_data_transfer_i,
    input  mst_mask_t   cr_is_shared_i,
    input  mst_mask_t   cr_pass_dirty_i,
    input  mst_mask_t   cr_error_i,
    // outcome
    output logic        snoop_done_o,
    output mst_mask_t   data_avail_o,
    output logic        shared_o,
    output logic        dirty_o,
    output mst_idx_t    first_responder_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_AC,
        ST_CR,
        ST_DONE
    } state_e;

    state_e    state_d, state_q;
    mst_mask_t ac_done_q, cr_done_q;
    mst_mask_t ac_hs, cr_hs;
    mst_mask_t data_avail_q, shared_q, dirty_q;

    assign ac_hs = ac_valid_o & ac_ready_i;
    assign cr_hs = cr_valid_i & cr_ready_o;

    // the initiator does not snoop itself, so it starts out done
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= ST_IDLE;
            ac_done_q <= '0;
            cr_done_q <= '0;
        end else begin
            state_q <= state_d;
            if (snoop_start_i) begin
                ac_done_q <= initiator_i;
                cr_done_q <= initiator_i;
            end else begin
                ac_done_q <= ac_done_q | ac_hs;
                cr_done_q <= cr_done_q | cr_hs;
            end
        end
    end

    always_comb begin
        state_d      = state_q;
        snoop_done_o = 1'b0;

        case (state_q)
            ST_IDLE: begin
                if (snoop_start_i) begin
                    state_d = ST_AC;
                end
            end
            ST_AC: begin
                if ((ac_done_q | ac_hs) == '1) begin
                    state_d = ST_CR;
                end
            end
            ST_CR: begin
                if ((cr_done_q | cr_hs) == '1) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                snoop_done_o = 1'b1;
                state_d      = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // --------------------
    // channel outputs
    // --------------------
    assign ac_valid_o = (state_q == ST_AC) ? ~ac_done_q : '0;
    assign cr_ready_o = (state_q == ST_CR) ? ~cr_done_q : '0;
    assign ac_addr_o  = snoop_addr_i;
    // invalidating snoops always go out as CleanInvalid
    assign ac_snoop_o = (snoop_kind_i == SNOOP_READ) ? snoop_code_i : SNP_CLEAN_INVALID;

    // --------------------
    // response flags
    // --------------------
    always_ff @(posedge clk_i) begin
        if (snoop_start_i) begin
            data_avail_q <= '0;
            shared_q     <= '0;
            dirty_q      <= '0;
        end else begin
            for (int i = 0; i < NO_MST_PORTS; i++) begin
                if (cr_hs[i]) begin
                    // an errored response never counts as data
                    data_avail_q[i] <= cr_data_transfer_i[i] & ~cr_error_i[i];
                    shared_q[i]     <= cr_is_shared_i[i];
                    dirty_q[i]      <= cr_pass_dirty_i[i];
                end
            end
        end
    end

    // lowest index with good data
    always_comb begin
        first_responder_o = '0;
        for (int i = NO_MST_PORTS - 1; i >= 0; i--) begin
            if (data_avail_q[i]) begin
                first_responder_o = mst_idx_t'(i);
            end
        end
    end

    assign data_avail_o = data_avail_q;
    assign shared_o     = |shared_q;
    assign dirty_o      = |dirty_q;

endmodule

/* testbench/ccu_snoop_responder.sv */
`timescale 1ns/10ps

module ccu_snoop_responder import ccu_ctrl_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  mst_mask_t ac_valid_i,
    output mst_mask_t ac_ready_o,
    output mst_mask_t cr_valid_o,
    input  mst_mask_t cr_ready_i
);

    integer    seed;
    integer    rnd;
    mst_mask_t pending_q;

    initial begin
        seed       = 32'hdd02;
        ac_ready_o = '0;
        cr_valid_o = '0;
        pending_q  = '0;
    end

    // each master takes the snoop after a random wait, then answers after another
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ac_ready_o <= '0;
            cr_valid_o <= '0;
            pending_q  <= '0;
        end else begin
            for (int i = 0; i < NO_MST_PORTS; i++) begin
                rnd = $random(seed);
                ac_ready_o[i] <= rnd[0] | rnd[1];
                if (ac_valid_i[i] && ac_ready_o[i]) begin
                    pending_q[i] <= 1'b1;
                end
                if (pending_q[i] && !cr_valid_o[i] && rnd[2]) begin
                    cr_valid_o[i] <= 1'b1;
                end
                if (cr_valid_o[i] && cr_ready_i[i]) begin
                    cr_valid_o[i] <= 1'b0;
                    pending_q[i]  <= 1'b0;
                end
            end
        end
    end

endmodule

/* testbench/tb_ccu_ctrl.sv */
`timescale 1ns/10ps

module tb_ccu_ctrl import ccu_ctrl_pkg::*; ();

    localparam int NUM_ROWS    = 9;
    localparam int ROW_CYCLES  = 300;
    localparam int TIMEOUT_NS  = (NUM_ROWS + 4) * ROW_CYCLES * 100;

    typedef struct {
        logic      is_write;
        addr_t     addr;
        axi_id_t   id;
        snoop_t    snoop;
        logic      lock;
        int        collide;
        int        full;
        mst_mask_t data;
        mst_mask_t err;
        snoop_t    exp_ac;
        logic      exp_mu_v;
        mu_op_e    exp_mu;
        logic      exp_su_v;
        su_op_e    exp_su;
    } row_t;

    row_t rows [NUM_ROWS];

    logic clk_i, rst_ni;
    logic ar_valid_i, ar_ready_o, ar_lock_i, aw_valid_i, aw_ready_o;
    addr_t ar_addr_i, aw_addr_i, ac_addr_o;
    axi_id_t ar_id_i, aw_id_i;
    snoop_t ar_snoop_i, ac_snoop_o;
    mst_mask_t ac_valid_o, ac_ready_i, cr_valid_i, cr_ready_o;
    mst_mask_t cr_data_transfer_i, cr_is_shared_i, cr_pass_dirty_i, cr_error_i;
    logic mu_valid_o, mu_ready_i, su_valid_o, su_ready_i;
    mu_op_e mu_op_o;
    su_op_e su_op_o;
    logic lookup_req_o, collision_i, b_queue_full_i, r_queue_full_i;

    // monitor state
    int        ac_cnt [NO_MST_PORTS];
    int        cr_cnt [NO_MST_PORTS];
    int        mu_cnt, su_cnt, cyc;
    mu_op_e    mu_seen;
    su_op_e    su_seen;
    snoop_t    exp_ac_q;
    addr_t     exp_addr_q;
    logic      check_ac;
    mst_mask_t init_mask_q;
    string     test_name;

    ccu_ctrl i_ccu_ctrl (.*);

    ccu_snoop_responder i_responder (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ac_valid_i (ac_valid_o),
        .ac_ready_o (ac_ready_i),
        .cr_valid_o (cr_valid_i),
        .cr_ready_i (cr_ready_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic report_mismatch(input string name, input longint exp, input longint act);
        $display("mismatch %s expected %0h actual %0h", name, exp, act);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // --------------------
    // table
    // --------------------
    task automatic fill_table();
        rows[0] = '{1'b0, 32'h1000, 6'h01, SNP_READ_SHARED, 1'b0, 0, 0, 4'b0000, 4'b0000,
                    SNP_READ_SHARED, 1'b1, SEND_AXI_REQ_R, 1'b0, READ_SNP_DATA};
        rows[1] = '{1'b0, 32'h1040, 6'h12, SNP_READ_SHARED, 1'b0, 0, 0, 4'b0100, 4'b0000,
                    SNP_READ_SHARED, 1'b0, SEND_AXI_REQ_R, 1'b1, READ_SNP_DATA};
        rows[2] = '{1'b0, 32'h2000, 6'h03, SNP_CLEAN_UNIQUE, 1'b0, 0, 0, 4'b1000, 4'b0000,
                    SNP_CLEAN_INVALID, 1'b1, SEND_AXI_REQ_WRITE_BACK_R,
                    1'b1, SEND_INVALID_ACK_R};
        rows[3] = '{1'b0, 32'h2080, 6'h24, SNP_READ_SHARED, 1'b1, 0, 0, 4'b0000, 4'b0000,
                    SNP_CLEAN_INVALID, 1'b1, SEND_AXI_REQ_R, 1'b0, READ_SNP_DATA};
        rows[4] = '{1'b1, 32'h3000, 6'h35, 4'h0, 1'b0, 0, 0, 4'b0010, 4'b0000,
                    SNP_CLEAN_INVALID, 1'b1, SEND_AXI_REQ_WRITE_BACK_W, 1'b0, READ_SNP_DATA};
        // errored data must not count
        rows[5] = '{1'b1, 32'h3100, 6'h06, 4'h0, 1'b0, 3, 2, 4'b0100, 4'b0100,
                    SNP_CLEAN_INVALID, 1'b1, SEND_AXI_REQ_W, 1'b0, READ_SNP_DATA};
        rows[6] = '{1'b0, 32'h4000, 6'h37, SNP_READ_SHARED, 1'b0, 2, 4, 4'b0011, 4'b0001,
                    SNP_READ_SHARED, 1'b0, SEND_AXI_REQ_R, 1'b1, READ_SNP_DATA};
        rows[7] = '{1'b0, 32'h4100, 6'h28, SNP_CLEAN_UNIQUE, 1'b0, 0, 3, 4'b0000, 4'b0000,
                    SNP_CLEAN_INVALID, 1'b0, SEND_AXI_REQ_R, 1'b1, SEND_INVALID_ACK_R};
        rows[8] = '{1'b0, 32'h5000, 6'h19, SNP_READ_SHARED, 1'b1, 1, 0, 4'b0001, 4'b0000,
                    SNP_CLEAN_INVALID, 1'b1, SEND_AXI_REQ_WRITE_BACK_R, 1'b0, READ_SNP_DATA};
    endtask

    // --------------------
    // monitor at the falling edge
    // --------------------
    always @(negedge clk_i) begin
        if (!rst_ni) begin
            // flops are reset by the first rising edge
            if (cyc > 0) begin
                assert (!ar_ready_o && !aw_ready_o && ac_valid_o == '0 && cr_ready_o == '0
                        && !mu_valid_o && !su_valid_o && !lookup_req_o)
                    else stop_with_error("an output is active during reset");
            end
        end else begin
            assert ((ac_valid_o & init_mask_q) == '0)
                else stop_with_error("snoop sent to the initiator port");
            assert (!(ar_ready_o && (collision_i || r_queue_full_i)))
                else stop_with_error("read accepted during collision or full read queue");
            assert (!(aw_ready_o && (collision_i || b_queue_full_i)))
                else stop_with_error("write accepted during collision or full write queue");
            assert (!(collision_i && ac_valid_o != '0))
                else stop_with_error("snoop sent during a collision");
            for (int i = 0; i < NO_MST_PORTS; i++) begin
                if (ac_valid_o[i] && ac_ready_i[i]) begin
                    ac_cnt[i]++;
                    assert (!check_ac || ac_snoop_o == exp_ac_q)
                        else report_mismatch({test_name, " ac_snoop"}, exp_ac_q, ac_snoop_o);
                    assert (!check_ac || ac_addr_o == exp_addr_q)
                        else report_mismatch({test_name, " ac_addr"}, exp_addr_q, ac_addr_o);
                end
                if (cr_valid_i[i] && cr_ready_o[i]) begin
                    cr_cnt[i]++;
                end
            end
            if (mu_valid_o && mu_ready_i) begin
                mu_cnt++;
                mu_seen = mu_op_o;
            end
            if (su_valid_o && su_ready_i) begin
                su_cnt++;
                su_seen = su_op_o;
            end
        end
    end

    // unit back-pressure follows a fixed cycle pattern
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        mu_ready_i <= (cyc % 3) != 1;
        su_ready_i <= (cyc % 4) != 2;
    end

    task automatic clear_counts(input mst_mask_t init);
        for (int i = 0; i < NO_MST_PORTS; i++) begin
            ac_cnt[i] = 0;
            cr_cnt[i] = 0;
        end
        mu_cnt = 0;
        su_cnt = 0;
        init_mask_q = init;
    endtask

    task automatic apply_row(input int idx);
        row_t      r;
        mst_mask_t init;
        int        lookups;
        logic      accepted;
        int        exp_n;
        r = rows[idx];
        test_name = $sformatf("row%0d", idx);
        init = mst_mask_t'(1) << r.id[ID_WIDTH-1 -: MST_IDX_BITS];
        clear_counts(init);
        exp_ac_q = r.exp_ac;
        exp_addr_q = r.addr;
        check_ac = 1'b1;
        lookups = 0;
        accepted = 1'b0;
        @(posedge clk_i);
        collision_i <= r.collide > 0;
        r_queue_full_i <= !r.is_write && r.full > 0;
        b_queue_full_i <= r.is_write && r.full > 0;
        cr_data_transfer_i <= r.data;
        cr_is_shared_i <= r.data;
        cr_pass_dirty_i <= r.data;
        cr_error_i <= r.err;
        ar_valid_i <= !r.is_write;
        aw_valid_i <= r.is_write;
        ar_addr_i <= r.addr;
        aw_addr_i <= r.addr;
        ar_id_i <= r.id;
        aw_id_i <= r.id;
        ar_snoop_i <= r.snoop;
        ar_lock_i <= r.lock;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = ar_ready_o || aw_ready_o;
            if (lookup_req_o) begin
                lookups++;
            end
            @(posedge clk_i);
            collision_i <= lookups < r.collide;
            r_queue_full_i <= !r.is_write && lookups < r.collide + r.full;
            b_queue_full_i <= r.is_write && lookups < r.collide + r.full;
            if (accepted) begin
                ar_valid_i <= 1'b0;
                aw_valid_i <= 1'b0;
            end
        end
        exp_n = int'(r.exp_mu_v) + int'(r.exp_su_v);
        while (mu_cnt + su_cnt < exp_n) begin
            @(negedge clk_i);
        end
        repeat (3) @(posedge clk_i);
        assert (mu_cnt == int'(r.exp_mu_v))
            else report_mismatch({test_name, " mu count"}, r.exp_mu_v, mu_cnt);
        assert (su_cnt == int'(r.exp_su_v))
            else report_mismatch({test_name, " su count"}, r.exp_su_v, su_cnt);
        assert (!r.exp_mu_v || mu_seen == r.exp_mu)
            else report_mismatch({test_name, " mu_op"}, r.exp_mu, mu_seen);
        assert (!r.exp_su_v || su_seen == r.exp_su)
            else report_mismatch({test_name, " su_op"}, r.exp_su, su_seen);
        for (int i = 0; i < NO_MST_PORTS; i++) begin
            assert (ac_cnt[i] == (init[i] ? 0 : 1))
                else report_mismatch({test_name, " ac count"}, !init[i], ac_cnt[i]);
            assert (cr_cnt[i] == (init[i] ? 0 : 1))
                else report_mismatch({test_name, " cr count"}, !init[i], cr_cnt[i]);
        end
    endtask

    // read and write offered together must alternate
    task automatic check_alternation();
        int   order [$];
        int   reads, writes;
        logic r_hs, w_hs;
        reads = 0;
        writes = 0;
        test_name = "pair";
        check_ac = 1'b0;
        clear_counts(4'b0010);
        @(posedge clk_i);
        cr_data_transfer_i <= '0;
        cr_error_i <= '0;
        ar_id_i <= 6'h10;
        aw_id_i <= 6'h11;
        ar_snoop_i <= SNP_READ_SHARED;
        ar_lock_i <= 1'b0;
        ar_valid_i <= 1'b1;
        aw_valid_i <= 1'b1;
        while (reads + writes < 4) begin
            @(negedge clk_i);
            r_hs = ar_ready_o;
            w_hs = aw_ready_o;
            @(posedge clk_i);
            if (r_hs) begin
                order.push_back(0);
                reads++;
                ar_valid_i <= reads < 2;
            end
            if (w_hs) begin
                order.push_back(1);
                writes++;
                aw_valid_i <= writes < 2;
            end
        end
        while (mu_cnt < 4) begin
            @(negedge clk_i);
        end
        for (int k = 0; k < 4; k++) begin
            assert (order[k] == k % 2)
                else report_mismatch({test_name, " order"}, k % 2, order[k]);
        end
    endtask

    // --------------------
    // main
    // --------------------
    initial begin
        clk_i = 1'b0;
        rst_ni = 1'b0;
        cyc = 0;
        ar_valid_i = 1'b0;
        ar_addr_i = '0;
        ar_id_i = '0;
        ar_snoop_i = '0;
        ar_lock_i = 1'b0;
        aw_valid_i = 1'b0;
        aw_addr_i = '0;
        aw_id_i = '0;
        cr_data_transfer_i = '0;
        cr_is_shared_i = '0;
        cr_pass_dirty_i = '0;
        cr_error_i = '0;
        mu_ready_i = 1'b0;
        su_ready_i = 1'b0;
        collision_i = 1'b0;
        b_queue_full_i = 1'b0;
        r_queue_full_i = 1'b0;
        check_ac = 1'b0;
        exp_ac_q = '0;
        exp_addr_q = '0;
        test_name = "reset";
        clear_counts('0);
        fill_table();
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        check_alternation();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        stop_with_error("timeout waiting for the DUT");
    end

endmodule

/* verilog.f */
source/ccu_ctrl_pkg.sv
source/ccu_req_decode.sv
source/ccu_snoop_execute.sv
source/ccu_dispatch_result.sv
source/ccu_ctrl.sv
testbench/ccu_snoop_responder.sv
testbench/tb_ccu_ctrl.sv
